//--- source/cluster_periph_pkg.sv
// ******************************
// Cluster peripheral package
// Bus widths, slot map and register offsets
// ******************************
`default_nettype none

package cluster_periph_pkg;

  // ******************************
  // Sizes
  // ******************************
  localparam int unsigned NB_CORES  = 4;
  localparam int unsigned CORE_W    = $clog2(NB_CORES);
  localparam int unsigned ADDR_W    = 12;
  localparam int unsigned DATA_W    = 32;
  localparam int unsigned ID_W      = NB_CORES + 1;
  localparam int unsigned NB_EVT    = 8;
  localparam int unsigned EVT_IDX_W = $clog2(NB_EVT);
  localparam int unsigned IRQ_ID_W  = 5;
  localparam int unsigned SLOT_W    = 2;
  // Word offset inside a slot, address bits 9:2
  localparam int unsigned OFF_W     = 8;

  localparam logic [DATA_W-1:0] BOOT_ADDR_RST = 32'h1C00_0000;
  localparam logic [DATA_W-1:0] ERR_RDATA     = 32'hDEAD_B33F;

  // Slot taken from address bits 11:10
  typedef enum logic [SLOT_W-1:0] {
    SLOT_CTRL  = 2'd0,
    SLOT_TIMER = 2'd1,
    SLOT_EU    = 2'd2,
    SLOT_NONE  = 2'd3
  } periph_slot_e;

  typedef enum logic {
    CORE_RUN   = 1'b0,
    CORE_SLEEP = 1'b1
  } core_state_e;

  // ******************************
  // Register offsets
  // ******************************
  localparam logic [OFF_W-1:0] CTRL_EOC       = 8'h00;
  localparam logic [OFF_W-1:0] CTRL_FETCH_EN  = 8'h02;
  localparam logic [OFF_W-1:0] CTRL_CG_EN     = 8'h08;
  localparam logic [OFF_W-1:0] CTRL_BOOT_BASE = 8'h10;

  localparam logic [OFF_W-1:0] TMR_CFG   = 8'h00;
  localparam logic [OFF_W-1:0] TMR_COUNT = 8'h01;
  localparam logic [OFF_W-1:0] TMR_CMP   = 8'h02;

  // Event unit registers, inside a 4-word block per core
  localparam logic [1:0] EU_MASK       = 2'd0;
  localparam logic [1:0] EU_BUFFER     = 2'd1;
  localparam logic [1:0] EU_BUFFER_CLR = 2'd2;
  localparam logic [1:0] EU_SLEEP      = 2'd3;

endpackage

`default_nettype wire

//--- source/periph_bus_demux.sv
// ******************************
// Peripheral bus demux
// Steers requests to a slot, returns responses
// ******************************
`timescale 1ns/100ps
`default_nettype none

module periph_bus_demux import cluster_periph_pkg::*; (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              req_i,
  input  logic [ADDR_W-1:0] addr_i,
  input  logic              wen_i,
  input  logic [DATA_W-1:0] wdata_i,
  input  logic [ID_W-1:0]   id_i,
  output logic              gnt_o,
  output logic              r_valid_o,
  output logic [DATA_W-1:0] r_rdata_o,
  output logic              r_opc_o,
  output logic [ID_W-1:0]   r_id_o,
  output logic              ctrl_req_o,
  output logic              tmr_req_o,
  output logic              eu_req_o,
  input  logic [DATA_W-1:0] ctrl_rdata_i,
  input  logic [DATA_W-1:0] tmr_rdata_i,
  input  logic [DATA_W-1:0] eu_rdata_i
);

  periph_slot_e slot;
  periph_slot_e slot_q;
  logic         rd_q;

  assign slot  = periph_slot_e'(addr_i[ADDR_W-1:ADDR_W-SLOT_W]);
  // Every slave grants in the request cycle
  assign gnt_o = req_i;

  assign ctrl_req_o = req_i && (slot == SLOT_CTRL);
  assign tmr_req_o  = req_i && (slot == SLOT_TIMER);
  assign eu_req_o   = req_i && (slot == SLOT_EU);

  // ******************************
  // Response bookkeeping
  // ******************************
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      r_valid_o <= 1'b0;
      slot_q    <= SLOT_CTRL;
      rd_q      <= 1'b0;
    end else begin
      r_valid_o <= req_i;
      if (req_i) begin
        slot_q <= slot;
        rd_q   <= wen_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      r_id_o <= id_i;
    end
  end

  // Unplugged slot answers with an error word and other writes return zero
  always_comb begin
    r_rdata_o = '0;
    case (slot_q)
      SLOT_CTRL:  r_rdata_o = rd_q ? ctrl_rdata_i : '0;
      SLOT_TIMER: r_rdata_o = rd_q ? tmr_rdata_i : '0;
      SLOT_EU:    r_rdata_o = rd_q ? eu_rdata_i : '0;
      default:    r_rdata_o = ERR_RDATA;
    endcase
  end

  assign r_opc_o = r_valid_o && (slot_q == SLOT_NONE);

  // Wdata only goes to the slaves
  logic unused_wdata;
  assign unused_wdata = ^wdata_i;

endmodule

`default_nettype wire

//--- source/cluster_ctrl_unit.sv
// ******************************
// Cluster control unit
// EOC, fetch enable, boot addresses, clock gate
// ******************************
`timescale 1ns/100ps
`default_nettype none

module cluster_ctrl_unit import cluster_periph_pkg::*; (
  input  logic                           clk_i,
  input  logic                           arst_n_i,
  input  logic                           req_i,
  input  logic [ADDR_W-1:0]              addr_i,
  input  logic                           wen_i,
  input  logic [DATA_W-1:0]              wdata_i,
  output logic [DATA_W-1:0]              rdata_o,
  output logic                           eoc_o,
  output logic [NB_CORES-1:0]            fetch_enable_o,
  output logic                           cluster_cg_en_o,
  output logic [NB_CORES-1:0][DATA_W-1:0] boot_addr_o
);

  logic [OFF_W-1:0]  off;
  logic [OFF_W-1:0]  boot_sel;
  logic              boot_hit;
  logic [CORE_W-1:0] boot_idx;
  logic              wr_en;
  logic [DATA_W-1:0] rd_val;

  assign off      = addr_i[OFF_W+1:2];
  assign wr_en    = req_i && !wen_i;

  // Boot addresses sit in a window starting at CTRL_BOOT_BASE
  assign boot_sel = off - CTRL_BOOT_BASE;
  assign boot_hit = boot_sel < OFF_W'(NB_CORES);
  assign boot_idx = boot_sel[CORE_W-1:0];

  // ******************************
  // Register writes
  // ******************************
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      eoc_o           <= 1'b0;
      fetch_enable_o  <= '0;
      cluster_cg_en_o <= 1'b0;
      boot_addr_o     <= {NB_CORES{BOOT_ADDR_RST}};
    end else if (wr_en) begin
      if (boot_hit) begin
        boot_addr_o[boot_idx] <= wdata_i;
      end else begin
        case (off)
          CTRL_EOC:      eoc_o           <= wdata_i[0];
          CTRL_FETCH_EN: fetch_enable_o  <= wdata_i[NB_CORES-1:0];
          CTRL_CG_EN:    cluster_cg_en_o <= wdata_i[0];
          default:       ;
        endcase
      end
    end
  end

  // ******************************
  // Read path
  // ******************************
  always_comb begin
    rd_val = '0;
    if (boot_hit) begin
      rd_val = boot_addr_o[boot_idx];
    end else begin
      case (off)
        CTRL_EOC:      rd_val = DATA_W'(eoc_o);
        CTRL_FETCH_EN: rd_val = DATA_W'(fetch_enable_o);
        CTRL_CG_EN:    rd_val = DATA_W'(cluster_cg_en_o);
        default:       rd_val = '0;
      endcase
    end
  end

  // Data is ready the cycle after the read
  always_ff @(posedge clk_i) begin
    if (req_i && wen_i) begin
      rdata_o <= rd_val;
    end
  end

endmodule

`default_nettype wire

//--- source/cluster_timer.sv
// ******************************
// Cluster timer
// Counter with compare match event
// ******************************
`timescale 1ns/100ps
`default_nettype none

module cluster_timer import cluster_periph_pkg::*; (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              req_i,
  input  logic [ADDR_W-1:0] addr_i,
  input  logic              wen_i,
  input  logic [DATA_W-1:0] wdata_i,
  output logic [DATA_W-1:0] rdata_o,
  output logic              evt_o,
  output logic              busy_o
);

  logic [OFF_W-1:0]  off;
  logic              wr_en;
  logic              en_q;
  logic [DATA_W-1:0] count_q;
  logic [DATA_W-1:0] cmp_q;
  logic              wrap;
  logic              clr;
  logic [DATA_W-1:0] rd_val;

  assign off   = addr_i[OFF_W+1:2];
  assign wr_en = req_i && !wen_i;
  assign clr   = wr_en && (off == TMR_CFG) && wdata_i[1];

  // Count wraps at the compare value
  assign wrap  = en_q && (count_q == cmp_q);

  // ******************************
  // Counter and config
  // ******************************
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      en_q    <= 1'b0;
      cmp_q   <= '0;
      count_q <= '0;
      evt_o   <= 1'b0;
    end else begin
      // With a zero compare value the event fires every other cycle
      evt_o <= wrap && !evt_o;
      if (wr_en && (off == TMR_CFG)) begin
        en_q <= wdata_i[0];
      end
      if (wr_en && (off == TMR_CMP)) begin
        cmp_q <= wdata_i;
      end
      if (clr) begin
        count_q <= '0;
      end else if (wr_en && (off == TMR_COUNT)) begin
        count_q <= wdata_i;
      end else if (en_q) begin
        count_q <= wrap ? '0 : count_q + 1'b1;
      end
    end
  end

  assign busy_o = en_q;

  // ******************************
  // Read path
  // ******************************
  always_comb begin
    case (off)
      TMR_CFG:   rd_val = DATA_W'(en_q);
      TMR_COUNT: rd_val = count_q;
      TMR_CMP:   rd_val = cmp_q;
      default:   rd_val = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (req_i && wen_i) begin
      rdata_o <= rd_val;
    end
  end

endmodule

`default_nettype wire

//--- source/event_unit.sv
// ******************************
// Event unit
// Event buffers, interrupts and core sleep
// ******************************
`timescale 1ns/100ps
`default_nettype none

module event_unit import cluster_periph_pkg::*; (
  input  logic                             clk_i,
  input  logic                             arst_n_i,
  input  logic                             req_i,
  input  logic [ADDR_W-1:0]                addr_i,
  input  logic                             wen_i,
  input  logic [DATA_W-1:0]                wdata_i,
  input  logic                             tmr_evt_i,
  input  logic [NB_EVT-2:0]                evt_i,
  input  logic [NB_CORES-1:0]              core_busy_i,
  input  logic [NB_CORES-1:0]              irq_ack_i,
  input  logic [NB_CORES-1:0][IRQ_ID_W-1:0] irq_ack_id_i,
  output logic [DATA_W-1:0]                rdata_o,
  output logic [NB_CORES-1:0]              irq_req_o,
  output logic [NB_CORES-1:0][IRQ_ID_W-1:0] irq_id_o,
  output logic [NB_CORES-1:0]              core_clk_en_o
);

  logic [OFF_W-1:0]                 off;
  logic                             eu_hit;
  logic [CORE_W-1:0]                eu_core;
  logic [1:0]                       eu_reg;
  logic                             wr_en;
  logic [NB_EVT-1:0]                evt_vec;
  logic [NB_CORES-1:0][NB_EVT-1:0]  mask_q;
  logic [NB_CORES-1:0][NB_EVT-1:0]  buf_q;
  logic [NB_CORES-1:0][NB_EVT-1:0]  pend;
  logic [NB_CORES-1:0][NB_EVT-1:0]  clr_mask;
  core_state_e [NB_CORES-1:0]       state_q;
  logic [DATA_W-1:0]                rd_val;

  // Offset is core * 4 + register
  assign off     = addr_i[OFF_W+1:2];
  assign eu_hit  = off[OFF_W-1:CORE_W+2] == '0;
  assign eu_core = off[CORE_W+1:2];
  assign eu_reg  = off[1:0];
  assign wr_en   = req_i && !wen_i && eu_hit;

  // Timer goes to bit 0 of every core
  assign evt_vec = {evt_i, tmr_evt_i};

  // ******************************
  // Pending events and irq id
  // ******************************
  always_comb begin
    for (int c = 0; c < NB_CORES; c++) begin
      pend[c]      = buf_q[c] & mask_q[c];
      irq_req_o[c] = |pend[c];
      irq_id_o[c]  = '0;
      // Lowest pending bit wins
      for (int b = NB_EVT - 1; b >= 0; b--) begin
        if (pend[c][b]) begin
          irq_id_o[c] = IRQ_ID_W'(b);
        end
      end
      core_clk_en_o[c] = !((state_q[c] == CORE_SLEEP) && !core_busy_i[c]);
    end
  end

  // Clears from software and from acknowledges
  always_comb begin
    for (int c = 0; c < NB_CORES; c++) begin
      clr_mask[c] = irq_ack_i[c] ? (NB_EVT'(1) << irq_ack_id_i[c]) : '0;
      if (wr_en && (eu_core == CORE_W'(c)) && (eu_reg == EU_BUFFER_CLR)) begin
        clr_mask[c] = clr_mask[c] | wdata_i[NB_EVT-1:0];
      end
    end
  end

  // ******************************
  // Per-core state
  // ******************************
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mask_q  <= '0;
      buf_q   <= '0;
      state_q <= {NB_CORES{CORE_RUN}};
    end else begin
      for (int c = 0; c < NB_CORES; c++) begin
        // A new event beats a clear in the same cycle
        buf_q[c] <= (buf_q[c] & ~clr_mask[c]) | evt_vec;
        if (wr_en && (eu_core == CORE_W'(c)) && (eu_reg == EU_MASK)) begin
          mask_q[c] <= wdata_i[NB_EVT-1:0];
        end
        if (irq_req_o[c]) begin
          state_q[c] <= CORE_RUN;
        end else if (wr_en && (eu_core == CORE_W'(c)) && (eu_reg == EU_SLEEP)) begin
          state_q[c] <= CORE_SLEEP;
        end
      end
    end
  end

  // Read path
  always_comb begin
    rd_val = '0;
    if (eu_hit) begin
      case (eu_reg)
        EU_MASK:   rd_val = DATA_W'(mask_q[eu_core]);
        EU_BUFFER: rd_val = DATA_W'(buf_q[eu_core]);
        EU_SLEEP:  rd_val = DATA_W'(state_q[eu_core]);
        default:   rd_val = '0;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i && wen_i) begin
      rdata_o <= rd_val;
    end
  end

  for (genvar c = 0; c < NB_CORES; c++) begin : g_ack_chk
    a_ack_pending: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      irq_ack_i[c] |-> (irq_ack_id_i[c] < NB_EVT) &&
                       buf_q[c][irq_ack_id_i[c][EVT_IDX_W-1:0]]);
  end

endmodule

`default_nettype wire

//--- source/cluster_peripherals.sv
// ******************************
// Cluster peripherals top
// Bus demux, control unit, timer, event unit
// ******************************
`timescale 1ns/100ps
`default_nettype none

module cluster_peripherals import cluster_periph_pkg::*; (
  input  logic                              clk_i,
  input  logic                              arst_n_i,
  input  logic                              req_i,
  input  logic [ADDR_W-1:0]                 addr_i,
  input  logic                              wen_i,
  input  logic [DATA_W-1:0]                 wdata_i,
  input  logic [ID_W-1:0]                   id_i,
  output logic                              gnt_o,
  output logic                              r_valid_o,
  output logic [DATA_W-1:0]                 r_rdata_o,
  output logic                              r_opc_o,
  output logic [ID_W-1:0]                   r_id_o,
  input  logic [NB_EVT-2:0]                 evt_i,
  input  logic [NB_CORES-1:0]               core_busy_i,
  input  logic [NB_CORES-1:0]               irq_ack_i,
  input  logic [NB_CORES-1:0][IRQ_ID_W-1:0] irq_ack_id_i,
  output logic [NB_CORES-1:0]               irq_req_o,
  output logic [NB_CORES-1:0][IRQ_ID_W-1:0] irq_id_o,
  output logic [NB_CORES-1:0]               core_clk_en_o,
  output logic [NB_CORES-1:0]               fetch_enable_o,
  output logic [NB_CORES-1:0][DATA_W-1:0]   boot_addr_o,
  output logic                              eoc_o,
  output logic                              cluster_cg_en_o,
  output logic                              busy_o
);

  logic              ctrl_req;
  logic              tmr_req;
  logic              eu_req;
  logic [DATA_W-1:0] ctrl_rdata;
  logic [DATA_W-1:0] tmr_rdata;
  logic [DATA_W-1:0] eu_rdata;
  logic              tmr_evt;

  // ******************************
  // Bus demux
  // ******************************
  periph_bus_demux i_demux (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .req_i        (req_i),
    .addr_i       (addr_i),
    .wen_i        (wen_i),
    .wdata_i      (wdata_i),
    .id_i         (id_i),
    .gnt_o        (gnt_o),
    .r_valid_o    (r_valid_o),
    .r_rdata_o    (r_rdata_o),
    .r_opc_o      (r_opc_o),
    .r_id_o       (r_id_o),
    .ctrl_req_o   (ctrl_req),
    .tmr_req_o    (tmr_req),
    .eu_req_o     (eu_req),
    .ctrl_rdata_i (ctrl_rdata),
    .tmr_rdata_i  (tmr_rdata),
    .eu_rdata_i   (eu_rdata)
  );

  // ******************************
  // Slaves
  // ******************************
  cluster_ctrl_unit i_ctrl (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .req_i           (ctrl_req),
    .addr_i          (addr_i),
    .wen_i           (wen_i),
    .wdata_i         (wdata_i),
    .rdata_o         (ctrl_rdata),
    .eoc_o           (eoc_o),
    .fetch_enable_o  (fetch_enable_o),
    .cluster_cg_en_o (cluster_cg_en_o),
    .boot_addr_o     (boot_addr_o)
  );

  cluster_timer i_timer (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .req_i    (tmr_req),
    .addr_i   (addr_i),
    .wen_i    (wen_i),
    .wdata_i  (wdata_i),
    .rdata_o  (tmr_rdata),
    .evt_o    (tmr_evt),
    .busy_o   (busy_o)
  );

  // Timer event is shared by all cores
  event_unit i_eu (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .req_i         (eu_req),
    .addr_i        (addr_i),
    .wen_i         (wen_i),
    .wdata_i       (wdata_i),
    .tmr_evt_i     (tmr_evt),
    .evt_i         (evt_i),
    .core_busy_i   (core_busy_i),
    .irq_ack_i     (irq_ack_i),
    .irq_ack_id_i  (irq_ack_id_i),
    .rdata_o       (eu_rdata),
    .irq_req_o     (irq_req_o),
    .irq_id_o      (irq_id_o),
    .core_clk_en_o (core_clk_en_o)
  );

endmodule

`default_nettype wire

//--- verification/tb_cluster_peripherals.sv
// ******************************
// Cluster peripherals testbench
// Table-driven bus accesses, events, sleep and timer
// ******************************
`timescale 1ns/100ps
`default_nettype none

module tb_cluster_peripherals import cluster_periph_pkg::*;;

  localparam logic RD          = 1'b1;
  localparam logic WR          = 1'b0;
  localparam int   TMR_CMP_VAL = 5;

  typedef struct packed {
    logic              rd;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [DATA_W-1:0] exp_rdata;
    logic              exp_opc;
  } access_t;

  logic                              clk_i;
  logic                              arst_n_i;
  logic                              req_i;
  logic [ADDR_W-1:0]                 addr_i;
  logic                              wen_i;
  logic [DATA_W-1:0]                 wdata_i;
  logic [ID_W-1:0]                   id_i;
  logic                              gnt_o;
  logic                              r_valid_o;
  logic [DATA_W-1:0]                 r_rdata_o;
  logic                              r_opc_o;
  logic [ID_W-1:0]                   r_id_o;
  logic [NB_EVT-2:0]                 evt_i;
  logic [NB_CORES-1:0]               core_busy_i;
  logic [NB_CORES-1:0]               irq_ack_i;
  logic [NB_CORES-1:0][IRQ_ID_W-1:0] irq_ack_id_i;
  logic [NB_CORES-1:0]               irq_req_o;
  logic [NB_CORES-1:0][IRQ_ID_W-1:0] irq_id_o;
  logic [NB_CORES-1:0]               core_clk_en_o;
  logic [NB_CORES-1:0]               fetch_enable_o;
  logic [NB_CORES-1:0][DATA_W-1:0]   boot_addr_o;
  logic                              eoc_o;
  logic                              cluster_cg_en_o;
  logic                              busy_o;

  access_t           stim_q[$];
  integer            seed = 32'h72e2_6cd2;
  int                mismatch_cnt = 0;
  int                fail_cnt = 0;
  int                cycle_cnt = 0;
  int                timeout_cycles = 2000;
  int                wait_cnt;
  logic [DATA_W-1:0] rdata;
  logic              opc;

  cluster_peripherals uut (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Run limit of table length x 4 plus margin for the event and timer sequences
  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= timeout_cycles) begin
      $display("Timeout: run did not finish within %0d cycles", timeout_cycles);
      $display("Summary: %0d mismatches, %0d other errors", mismatch_cnt, fail_cnt);
      $display("Test failed");
      $finish;
    end
  end

  // ******************************
  // Helpers
  // ******************************
  task automatic report_mismatch(input string name, input logic [DATA_W-1:0] exp,
                                 input logic [DATA_W-1:0] act);
    $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
    mismatch_cnt++;
  endtask

  task automatic report_fail(input string what);
    $display("ERROR: %s", what);
    fail_cnt++;
  endtask

  function automatic logic [ADDR_W-1:0] make_addr(input logic [SLOT_W-1:0] slot,
                                                  input logic [OFF_W-1:0] off);
    return {slot, off, 2'b00};
  endfunction

  // Event unit block of four words per core
  function automatic logic [OFF_W-1:0] eu_off(input int core, input logic [1:0] rsel);
    return OFF_W'(core * 4) + OFF_W'(rsel);
  endfunction

  // One bus access with its response in the next cycle under the same id
  task automatic bus_access(input logic rd, input logic [ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] wdata,
                            output logic [DATA_W-1:0] rsp_data, output logic rsp_opc);
    logic [ID_W-1:0] id;
    int              rnd;
    @(negedge clk_i);
    rnd     = $random(seed);
    id      = rnd[ID_W-1:0];
    req_i   = 1'b1;
    addr_i  = addr;
    wen_i   = rd;
    wdata_i = wdata;
    id_i    = id;
    #1;
    if (gnt_o !== 1'b1) report_mismatch("gnt_o", 1, gnt_o);
    if (r_valid_o !== 1'b0) report_mismatch("r_valid_o", 0, r_valid_o);
    @(negedge clk_i);
    if (r_valid_o !== 1'b1) report_mismatch("r_valid_o", 1, r_valid_o);
    if (r_id_o !== id) report_mismatch("r_id_o", id, r_id_o);
    rsp_data = r_rdata_o;
    rsp_opc  = r_opc_o;
    req_i    = 1'b0;
    wen_i    = 1'b1;
  endtask

  task automatic read_expect(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] exp,
                             input string name);
    logic [DATA_W-1:0] val;
    logic              err;
    bus_access(RD, addr, '0, val, err);
    if (val !== exp) report_mismatch(name, exp, val);
    if (err !== 1'b0) report_mismatch("r_opc_o", 0, err);
  endtask

  task automatic add_entry(input logic rd, input logic [ADDR_W-1:0] addr,
                           input logic [DATA_W-1:0] wdata, input logic [DATA_W-1:0] exp,
                           input logic exp_opc);
    stim_q.push_back('{rd, addr, wdata, exp, exp_opc});
  endtask

  task automatic load_table();
    for (int i = 0; i < NB_CORES; i++) begin
      add_entry(RD, make_addr(SLOT_CTRL, CTRL_BOOT_BASE + OFF_W'(i)), '0, BOOT_ADDR_RST, 0);
    end
    add_entry(RD, make_addr(SLOT_CTRL, CTRL_EOC), '0, '0, 0);
    add_entry(RD, make_addr(SLOT_CTRL, CTRL_FETCH_EN), '0, '0, 0);
    add_entry(RD, make_addr(SLOT_CTRL, CTRL_CG_EN), '0, '0, 0);
    add_entry(WR, make_addr(SLOT_CTRL, CTRL_BOOT_BASE), 32'h1C00_8000, '0, 0);
    add_entry(WR, make_addr(SLOT_CTRL, CTRL_BOOT_BASE + 8'd3), 32'h1C01_0040, '0, 0);
    add_entry(RD, make_addr(SLOT_CTRL, CTRL_BOOT_BASE), '0, 32'h1C00_8000, 0);
    add_entry(RD, make_addr(SLOT_CTRL, CTRL_BOOT_BASE + 8'd3), '0, 32'h1C01_0040, 0);
    add_entry(RD, make_addr(SLOT_CTRL, CTRL_BOOT_BASE + 8'd1), '0, BOOT_ADDR_RST, 0);
    // Only one fetch-enable bit per core is kept
    add_entry(WR, make_addr(SLOT_CTRL, CTRL_FETCH_EN), 32'h0000_00F5, '0, 0);
    add_entry(RD, make_addr(SLOT_CTRL, CTRL_FETCH_EN), '0, 32'h5, 0);
    add_entry(WR, make_addr(SLOT_CTRL, CTRL_FETCH_EN), 32'hA, '0, 0);
    add_entry(RD, make_addr(SLOT_CTRL, CTRL_FETCH_EN), '0, 32'hA, 0);
    add_entry(WR, make_addr(SLOT_CTRL, CTRL_EOC), 32'h1, '0, 0);
    add_entry(RD, make_addr(SLOT_CTRL, CTRL_EOC), '0, 32'h1, 0);
    add_entry(WR, make_addr(SLOT_CTRL, CTRL_CG_EN), 32'h1, '0, 0);
    add_entry(RD, make_addr(SLOT_CTRL, CTRL_CG_EN), '0, 32'h1, 0);
    add_entry(WR, make_addr(SLOT_CTRL, 8'h05), 32'h1234, '0, 0);
    add_entry(RD, make_addr(SLOT_CTRL, 8'h05), '0, '0, 0);
    // Writes to the unplugged slot must not reach the control unit
    add_entry(RD, make_addr(SLOT_NONE, 8'h00), '0, ERR_RDATA, 1);
    add_entry(WR, make_addr(SLOT_NONE, CTRL_EOC), '0, ERR_RDATA, 1);
    add_entry(WR, make_addr(SLOT_NONE, CTRL_BOOT_BASE), '0, ERR_RDATA, 1);
    add_entry(RD, make_addr(SLOT_CTRL, CTRL_EOC), '0, 32'h1, 0);
    add_entry(RD, make_addr(SLOT_CTRL, CTRL_BOOT_BASE), '0, 32'h1C00_8000, 0);
    add_entry(RD, make_addr(SLOT_TIMER, TMR_CMP), '0, '0, 0);
    add_entry(RD, make_addr(SLOT_EU, eu_off(2, EU_MASK)), '0, '0, 0);
  endtask

  task automatic check_reset_state();
    if (eoc_o !== 1'b0) report_mismatch("eoc_o", 0, eoc_o);
    if (fetch_enable_o !== '0) report_mismatch("fetch_enable_o", 0, fetch_enable_o);
    if (cluster_cg_en_o !== 1'b0) report_mismatch("cluster_cg_en_o", 0, cluster_cg_en_o);
    if (irq_req_o !== '0) report_mismatch("irq_req_o", 0, irq_req_o);
    if (r_valid_o !== 1'b0) report_mismatch("r_valid_o", 0, r_valid_o);
    if (busy_o !== 1'b0) report_mismatch("busy_o", 0, busy_o);
    if (core_clk_en_o !== 4'hF) report_mismatch("core_clk_en_o", 4'hF, core_clk_en_o);
    for (int i = 0; i < NB_CORES; i++) begin
      if (boot_addr_o[i] !== BOOT_ADDR_RST) begin
        report_mismatch($sformatf("boot_addr_o[%0d]", i), BOOT_ADDR_RST, boot_addr_o[i]);
      end
    end
  endtask

  // ******************************
  // Main sequence
  // ******************************
  initial begin
    arst_n_i     = 1'b0;
    req_i        = 1'b0;
    addr_i       = '0;
    wen_i        = 1'b1;
    wdata_i      = '0;
    id_i         = '0;
    evt_i        = '0;
    core_busy_i  = '0;
    irq_ack_i    = '0;
    irq_ack_id_i = '0;
    load_table();
    timeout_cycles = stim_q.size() * 4 + 2000;
    repeat (10) @(negedge clk_i);
    arst_n_i = 1'b1;
    @(negedge clk_i);
    check_reset_state();

    foreach (stim_q[i]) begin
      bus_access(stim_q[i].rd, stim_q[i].addr, stim_q[i].wdata, rdata, opc);
      if (rdata !== stim_q[i].exp_rdata) begin
        report_mismatch($sformatf("r_rdata_o (entry %0d)", i), stim_q[i].exp_rdata, rdata);
      end
      if (opc !== stim_q[i].exp_opc) begin
        report_mismatch($sformatf("r_opc_o (entry %0d)", i), stim_q[i].exp_opc, opc);
      end
    end
    if (eoc_o !== 1'b1) report_mismatch("eoc_o", 1, eoc_o);
    if (cluster_cg_en_o !== 1'b1) report_mismatch("cluster_cg_en_o", 1, cluster_cg_en_o);
    if (fetch_enable_o !== 4'hA) report_mismatch("fetch_enable_o", 4'hA, fetch_enable_o);
    if (boot_addr_o[3] !== 32'h1C01_0040) report_mismatch("boot_addr_o[3]", 32'h1C01_0040,
                                                          boot_addr_o[3]);

    // Core 1 listens to events 1 and 3 while event 4 stays masked
    bus_access(WR, make_addr(SLOT_EU, eu_off(1, EU_MASK)), 32'h0A, rdata, opc);
    @(negedge clk_i);
    evt_i = 7'b000_1101;
    @(negedge clk_i);
    evt_i = '0;
    if (irq_req_o !== 4'b0010) report_mismatch("irq_req_o", 4'b0010, irq_req_o);
    if (irq_id_o[1] !== 5'd1) report_mismatch("irq_id_o[1]", 1, irq_id_o[1]);
    irq_ack_i[1]    = 1'b1;
    irq_ack_id_i[1] = 5'd1;
    @(negedge clk_i);
    if (irq_req_o[1] !== 1'b1) report_mismatch("irq_req_o[1]", 1, irq_req_o[1]);
    if (irq_id_o[1] !== 5'd3) report_mismatch("irq_id_o[1]", 3, irq_id_o[1]);
    irq_ack_id_i[1] = 5'd3;
    @(negedge clk_i);
    irq_ack_i = '0;
    if (irq_req_o !== 4'b0000) report_mismatch("irq_req_o", 0, irq_req_o);
    read_expect(make_addr(SLOT_EU, eu_off(1, EU_BUFFER)), 32'h10, "EU_BUFFER core 1");
    read_expect(make_addr(SLOT_EU, eu_off(0, EU_BUFFER)), 32'h1A, "EU_BUFFER core 0");

    // Sleep on core 2 until event 6 wakes it
    bus_access(WR, make_addr(SLOT_EU, eu_off(2, EU_MASK)), 32'h40, rdata, opc);
    bus_access(WR, make_addr(SLOT_EU, eu_off(2, EU_SLEEP)), '0, rdata, opc);
    if (core_clk_en_o !== 4'b1011) report_mismatch("core_clk_en_o", 4'b1011, core_clk_en_o);
    core_busy_i = 4'b0100;
    @(negedge clk_i);
    if (core_clk_en_o !== 4'b1111) report_mismatch("core_clk_en_o", 4'b1111, core_clk_en_o);
    core_busy_i = '0;
    @(negedge clk_i);
    if (core_clk_en_o !== 4'b1011) report_mismatch("core_clk_en_o", 4'b1011, core_clk_en_o);
    evt_i    = 7'b010_0000;
    wait_cnt = 0;
    while (core_clk_en_o[2] !== 1'b1 && wait_cnt < 4) begin
      @(negedge clk_i);
      wait_cnt++;
    end
    if (core_clk_en_o !== 4'b1111) report_fail("core 2 did not wake on its masked event");
    if (irq_id_o[2] !== 5'd6) report_mismatch("irq_id_o[2]", 6, irq_id_o[2]);
    evt_i           = '0;
    irq_ack_i[2]    = 1'b1;
    irq_ack_id_i[2] = 5'd6;
    @(negedge clk_i);
    irq_ack_i = '0;
    if (irq_req_o[2] !== 1'b0) report_mismatch("irq_req_o[2]", 0, irq_req_o[2]);

    // ******************************
    // Timer compare event
    // ******************************
    bus_access(WR, make_addr(SLOT_EU, eu_off(3, EU_MASK)), 32'h01, rdata, opc);
    bus_access(WR, make_addr(SLOT_TIMER, TMR_CMP), TMR_CMP_VAL, rdata, opc);
    bus_access(WR, make_addr(SLOT_TIMER, TMR_CFG), 32'h3, rdata, opc);
    if (busy_o !== 1'b1) report_mismatch("busy_o", 1, busy_o);
    wait_cnt = 0;
    while (irq_req_o[3] !== 1'b1 && wait_cnt < TMR_CMP_VAL + 3) begin
      @(negedge clk_i);
      wait_cnt++;
    end
    if (irq_req_o[3] !== 1'b1) report_fail("timer event did not reach core 3 in time");
    for (int c = 0; c < NB_CORES; c++) begin
      bus_access(RD, make_addr(SLOT_EU, eu_off(c, EU_BUFFER)), '0, rdata, opc);
      if (rdata[0] !== 1'b1) report_mismatch($sformatf("EU_BUFFER[0] core %0d", c), 1, rdata[0]);
    end
    bus_access(RD, make_addr(SLOT_TIMER, TMR_COUNT), '0, rdata, opc);
    if (rdata > TMR_CMP_VAL) begin
      report_fail($sformatf("TMR_COUNT %h is above the compare value %h", rdata, TMR_CMP_VAL));
    end
    bus_access(WR, make_addr(SLOT_TIMER, TMR_CFG), '0, rdata, opc);
    if (busy_o !== 1'b0) report_mismatch("busy_o", 0, busy_o);

    $display("Summary: %0d mismatches, %0d other errors", mismatch_cnt, fail_cnt);
    if (mismatch_cnt == 0 && fail_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
source/cluster_periph_pkg.sv
source/periph_bus_demux.sv
source/cluster_ctrl_unit.sv
source/cluster_timer.sv
source/event_unit.sv
source/cluster_peripherals.sv
verification/tb_cluster_peripherals.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
LINTFLAGS ?= --lint-only --timing -Wall
TOP       := tb_cluster_peripherals
FILELIST  := sim.f
OBJ_DIR   := obj_dir
PASS_MSG  := Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
